// File: mipsPkg.sv
`default_nettype none

package mipsPkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regAddr_t;
  typedef logic [15:0] imm16_t;

  // primary opcode field, bits 31:26
  typedef enum logic [5:0] {
    opR    = 6'h00,
    opJ    = 6'h02,
    opJal  = 6'h03,
    opBeq  = 6'h04,
    opBne  = 6'h05,
    opAddi = 6'h08,
    opLw   = 6'h23,
    opSw   = 6'h2b
  } opcode_t;

  // funct field of R-type, bits 5:0
  typedef enum logic [5:0] {
    fnJr  = 6'h08,
    fnAdd = 6'h20,
    fnSub = 6'h22,
    fnAnd = 6'h24,
    fnOr  = 6'h25,
    fnSlt = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {
    aluAdd = 3'd0,
    aluSub = 3'd1,
    aluAnd = 3'd2,
    aluOr  = 3'd3,
    aluSlt = 3'd4
  } aluOp_t;

  typedef struct packed {
    logic   memToReg;
    logic   memWrite;
    logic   branchEq;
    logic   branchNe;
    logic   aluSrcImm;
    logic   regDstRd;
    logic   regWrite;
    logic   jump;
    logic   link;
    logic   jumpReg;
    aluOp_t aluOp;
  } ctrl_t;

  // one retired instruction as seen on the trace port
  typedef struct packed {
    word_t    pc;
    word_t    instr;
    logic     regWe;
    regAddr_t regAddr;
    word_t    regData;
    logic     memWe;
    word_t    memAddr;
    word_t    memData;
  } commit_t;

  localparam word_t    resetPc   = 32'h0000_0000;
  localparam int       imemWords = 64;
  localparam int       dmemWords = 64;
  localparam regAddr_t linkReg   = 5'd31;

endpackage

`default_nettype wire

// File: mipsControl.sv
`default_nettype none

module mipsControl import mipsPkg::*; (
  input  word_t instr,
  output ctrl_t ctrl
);

  always_comb begin
    // unknown encodings fall through as a no-op
    ctrl = '0;
    case (opcode_t'(instr[31:26]))
      opR: begin
        ctrl.regDstRd = 1'b1;
        ctrl.regWrite = 1'b1;
        case (funct_t'(instr[5:0]))
          fnAdd: ctrl.aluOp = aluAdd;
          fnSub: ctrl.aluOp = aluSub;
          fnAnd: ctrl.aluOp = aluAnd;
          fnOr:  ctrl.aluOp = aluOr;
          fnSlt: ctrl.aluOp = aluSlt;
          fnJr: begin
            // jr only redirects, nothing written back
            ctrl.regWrite = 1'b0;
            ctrl.jumpReg  = 1'b1;
          end
          default: ctrl = '0;
        endcase
      end
      opAddi: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.aluOp     = aluAdd;
      end
      opLw: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memToReg  = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.aluOp     = aluAdd;
      end
      opSw: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memWrite  = 1'b1;
        ctrl.aluOp     = aluAdd;
      end
      opBeq: begin
        ctrl.branchEq = 1'b1;
        ctrl.aluOp    = aluSub;
      end
      opBne: begin
        ctrl.branchNe = 1'b1;
        ctrl.aluOp    = aluSub;
      end
      opJ: ctrl.jump = 1'b1;
      opJal: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: mipsAlu.sv
`default_nettype none

module mipsAlu import mipsPkg::*; (
  input  word_t  a,
  input  word_t  b,
  input  aluOp_t op,
  output word_t  result,
  output logic   zero
);

  always_comb begin
    case (op)
      aluAdd: result = a + b;
      aluSub: result = a - b;
      aluAnd: result = a & b;
      aluOr:  result = a | b;
      // signed compare, result is 0 or 1
      aluSlt: begin
        if ($signed(a) < $signed(b)) begin
          result = 32'd1;
        end else begin
          result = 32'd0;
        end
      end
      default: result = '0;
    endcase
  end

  // branches compare through the sub result
  assign zero = (result == '0);

endmodule

`default_nettype wire

// File: mipsRegFile.sv
`default_nettype none

module mipsRegFile import mipsPkg::*; (
  input  logic     clk,
  input  logic     arstN,
  input  regAddr_t rAddr1,
  input  regAddr_t rAddr2,
  input  regAddr_t wAddr,
  input  word_t    wData,
  input  logic     we,
  output word_t    rData1,
  output word_t    rData2
);

  // $zero has no storage
  word_t regs [1:31];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (wAddr != '0)) begin
      regs[wAddr] <= wData;
    end
  end

  assign rData1 = (rAddr1 == '0) ? '0 : regs[rAddr1];
  assign rData2 = (rAddr2 == '0) ? '0 : regs[rAddr2];

endmodule

`default_nettype wire

// File: mipsCpu.sv
`default_nettype none

module mipsCpu import mipsPkg::*; (
  input  logic     arstN,
  input  word_t    pc,
  input  word_t    instr,
  output word_t    pcNext,
  output regAddr_t rfRAddr1,
  output regAddr_t rfRAddr2,
  output regAddr_t rfWAddr,
  output word_t    rfWData,
  output logic     rfWe,
  input  word_t    rfRData1,
  input  word_t    rfRData2,
  output word_t    dmAddr,
  output word_t    dmWData,
  output logic     dmWe,
  input  word_t    dmRData,
  output commit_t  trace
);

  ctrl_t    ctrl;
  regAddr_t rs;
  regAddr_t rt;
  regAddr_t rd;
  imm16_t   imm;
  word_t    immExt;
  word_t    aluB;
  word_t    aluResult;
  logic     aluZero;
  word_t    pcPlus4;
  word_t    pcBranch;
  word_t    pcJump;
  logic     branchTaken;

  // instruction fields
  assign rs  = instr[25:21];
  assign rt  = instr[20:16];
  assign rd  = instr[15:11];
  assign imm = instr[15:0];

  mipsControl control0 (
    .instr (instr),
    .ctrl  (ctrl)
  );

  assign immExt = {{16{imm[15]}}, imm};
  assign aluB   = ctrl.aluSrcImm ? immExt : rfRData2;

  mipsAlu alu0 (
    .a      (rfRData1),
    .b      (aluB),
    .op     (ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  // register file side
  assign rfRAddr1 = rs;
  assign rfRAddr2 = rt;
  assign rfWAddr  = ctrl.link ? linkReg : (ctrl.regDstRd ? rd : rt);
  assign rfWData  = ctrl.link ? pcPlus4 : (ctrl.memToReg ? dmRData : aluResult);
  // no writes while reset is held
  assign rfWe     = ctrl.regWrite & arstN;

  // data memory side
  assign dmAddr  = aluResult;
  assign dmWData = rfRData2;
  assign dmWe    = ctrl.memWrite & arstN;

  // next pc
  assign pcPlus4     = pc + 32'd4;
  assign pcBranch    = pcPlus4 + {immExt[29:0], 2'b00};
  assign pcJump      = {pcPlus4[31:28], instr[25:0], 2'b00};
  assign branchTaken = (ctrl.branchEq & aluZero) | (ctrl.branchNe & ~aluZero);

  always_comb begin
    if (ctrl.jumpReg) begin
      pcNext = rfRData1;
    end else if (ctrl.jump) begin
      pcNext = pcJump;
    end else if (branchTaken) begin
      pcNext = pcBranch;
    end else begin
      pcNext = pcPlus4;
    end
  end

  // commit record of this cycle's instruction
  always_comb begin
    trace.pc      = pc;
    trace.instr   = instr;
    trace.regWe   = rfWe;
    trace.regAddr = rfWAddr;
    trace.regData = rfWData;
    trace.memWe   = dmWe;
    trace.memAddr = dmAddr;
    trace.memData = dmWData;
  end

endmodule

`default_nettype wire

// File: mipsFetch.sv
`default_nettype none

module mipsFetch import mipsPkg::*; (
  input  logic  clk,
  input  logic  arstN,
  input  word_t pcNext,
  output word_t pc,
  output word_t instr
);

  word_t rom [imemWords];

  initial begin
    $readmemh("program.hex", rom);
  end

  // program counter, one instruction per cycle
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= resetPc;
    end else begin
      pc <= pcNext;
    end
  end

  // word index, byte offset dropped
  assign instr = rom[pc[$clog2(imemWords)+1:2]];

endmodule

`default_nettype wire

// File: mipsDataMem.sv
`default_nettype none

module mipsDataMem import mipsPkg::*; (
  input  logic  clk,
  input  word_t addr,
  input  word_t wData,
  input  logic  we,
  output word_t rData
);

  word_t mem [dmemWords];

  // word index from the bits above the byte offset
  logic [$clog2(dmemWords)-1:0] wordIdx;

  assign wordIdx = addr[$clog2(dmemWords)+1:2];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wordIdx] <= wData;
    end
  end

  // read is asynchronous
  assign rData = mem[wordIdx];

endmodule

`default_nettype wire

// File: mipsSystem.sv
`default_nettype none

module mipsSystem import mipsPkg::*; (
  input  logic    clk,
  input  logic    arstN,
  output commit_t trace
);

  word_t    pc;
  word_t    pcNext;
  word_t    instr;
  regAddr_t rfRAddr1;
  regAddr_t rfRAddr2;
  regAddr_t rfWAddr;
  word_t    rfWData;
  logic     rfWe;
  word_t    rfRData1;
  word_t    rfRData2;
  word_t    dmAddr;
  word_t    dmWData;
  logic     dmWe;
  word_t    dmRData;

  mipsFetch fetch0 (
    .clk    (clk),
    .arstN  (arstN),
    .pcNext (pcNext),
    .pc     (pc),
    .instr  (instr)
  );

  mipsCpu cpu0 (
    .arstN    (arstN),
    .pc       (pc),
    .instr    (instr),
    .pcNext   (pcNext),
    .rfRAddr1 (rfRAddr1),
    .rfRAddr2 (rfRAddr2),
    .rfWAddr  (rfWAddr),
    .rfWData  (rfWData),
    .rfWe     (rfWe),
    .rfRData1 (rfRData1),
    .rfRData2 (rfRData2),
    .dmAddr   (dmAddr),
    .dmWData  (dmWData),
    .dmWe     (dmWe),
    .dmRData  (dmRData),
    .trace    (trace)
  );

  mipsRegFile regFile0 (
    .clk    (clk),
    .arstN  (arstN),
    .rAddr1 (rfRAddr1),
    .rAddr2 (rfRAddr2),
    .wAddr  (rfWAddr),
    .wData  (rfWData),
    .we     (rfWe),
    .rData1 (rfRData1),
    .rData2 (rfRData2)
  );

  mipsDataMem dataMem0 (
    .clk   (clk),
    .addr  (dmAddr),
    .wData (dmWData),
    .we    (dmWe),
    .rData (dmRData)
  );

endmodule

`default_nettype wire

// File: mipsSystem_properties.sv
`default_nettype none

module mipsSystemProperties import mipsPkg::*; (
  input logic     clk,
  input logic     arstN,
  input word_t    pc,
  input regAddr_t rfRAddr1,
  input regAddr_t rfRAddr2,
  input word_t    rfRData1,
  input word_t    rfRData2,
  input logic     rfWe,
  input logic     dmWe,
  input word_t    dmAddr,
  input commit_t  trace
);

  // failed property count
  int violations = 0;

  // nothing written or reported while reset is held
  noWriteInReset: assert property (@(posedge clk)
    !arstN |-> (!rfWe && !dmWe && !trace.regWe && !trace.memWe))
    else begin
      $error("write enable active while arstN is low");
      violations++;
    end

  // $zero reads back zero, so no write ever lands there
  zeroRegPort1: assert property (@(posedge clk) (rfRAddr1 == '0) |-> (rfRData1 == '0))
    else begin
      $error("register zero read nonzero on port 1");
      violations++;
    end
  zeroRegPort2: assert property (@(posedge clk) (rfRAddr2 == '0) |-> (rfRData2 == '0))
    else begin
      $error("register zero read nonzero on port 2");
      violations++;
    end

  pcAligned: assert property (@(posedge clk) disable iff (!arstN) (pc[1:0] == 2'b00))
    else begin
      $error("pc is not word aligned");
      violations++;
    end

  memWriteInRange: assert property (@(posedge clk) disable iff (!arstN)
    dmWe |-> (dmAddr < word_t'(dmemWords * 4)))
    else begin
      $error("data memory write outside the RAM");
      violations++;
    end

endmodule

bind mipsSystem mipsSystemProperties props0 (
  .clk      (clk),
  .arstN    (arstN),
  .pc       (pc),
  .rfRAddr1 (rfRAddr1),
  .rfRAddr2 (rfRAddr2),
  .rfRData1 (rfRData1),
  .rfRData2 (rfRData2),
  .rfWe     (rfWe),
  .dmWe     (dmWe),
  .dmAddr   (dmAddr),
  .trace    (trace)
);

`default_nettype wire

// File: tbMipsSystem.sv
`default_nettype none

module tbMipsSystem import mipsPkg::*; ();

  logic    clk;
  logic    arstN;
  commit_t trace;

  // ISA-level shadow state
  word_t shadowRegs [32];
  word_t shadowMem [word_t];
  word_t expPc;
  bit    reached [string];
  bit    done;
  int    checkCount [6];
  int    failCount [6];
  int    otherErrors;
  int    totalChecks;
  int    totalErrors;
  string testNames [6] = '{"reset", "alu", "memory", "branch", "jump", "coverage"};
  string points [10] = '{"negative slt", "write to zero", "load after store", "beq taken",
    "beq not taken", "bne taken", "bne not taken", "j", "jal", "jr"};

  mipsSystem dut0 (
    .clk   (clk),
    .arstN (arstN),
    .trace (trace)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  task automatic checkValue(input int testIdx, input string field, input word_t expected,
                            input word_t actual);
    checkCount[testIdx]++;
    assert (actual == expected) else begin
      $display("error %s %s: expected %h, actual %h", testNames[testIdx], field, expected,
               actual);
      failCount[testIdx]++;
    end
  endtask

  task automatic reportTest(input int testIdx);
    $display("test %s: %0d checks, %0d errors", testNames[testIdx], checkCount[testIdx],
             failCount[testIdx]);
  endtask

  // predict one instruction from the ISA rules, compare, then update the model
  task automatic retireOne();
    word_t      instr;
    word_t      a;
    word_t      b;
    word_t      immExt;
    word_t      pcPlus4;
    word_t      nextPc;
    word_t      regData;
    word_t      memAddr;
    logic [5:0] op;
    regAddr_t   regAddr;
    logic       regWe;
    logic       memWe;
    int         testIdx;
    instr   = trace.instr;
    op      = instr[31:26];
    a       = shadowRegs[instr[25:21]];
    b       = shadowRegs[instr[20:16]];
    immExt  = {{16{instr[15]}}, instr[15:0]};
    pcPlus4 = expPc + 32'd4;
    nextPc  = pcPlus4;
    regWe   = 1'b1;
    regAddr = instr[20:16];
    regData = a + immExt;
    memWe   = 1'b0;
    memAddr = a + immExt;
    testIdx = 1;
    case (op)
      6'h00: begin
        regAddr = instr[15:11];
        case (instr[5:0])
          6'h20: regData = a + b;
          6'h22: regData = a - b;
          6'h24: regData = a & b;
          6'h25: regData = a | b;
          6'h2a: begin
            regData = {31'd0, $signed(a) < $signed(b)};
            if (a[31] || b[31]) begin
              reached["negative slt"] = 1'b1;
            end
          end
          6'h08: begin
            regWe   = 1'b0;
            nextPc  = a;
            testIdx = 4;
            reached["jr"] = 1'b1;
          end
          default: begin
            $display("unknown R-type funct in %h at pc %h", instr, expPc);
            otherErrors++;
          end
        endcase
        if (regWe && regAddr == '0) begin
          reached["write to zero"] = 1'b1;
        end
      end
      // addi keeps the defaults
      6'h08: testIdx = 1;
      6'h23: begin
        testIdx = 2;
        if (shadowMem.exists(memAddr)) begin
          regData = shadowMem[memAddr];
          reached["load after store"] = 1'b1;
        end else begin
          $display("lw at pc %h reads a word that was never stored", expPc);
          otherErrors++;
        end
      end
      6'h2b: begin
        testIdx = 2;
        regWe   = 1'b0;
        memWe   = 1'b1;
      end
      6'h04, 6'h05: begin
        testIdx = 3;
        regWe   = 1'b0;
        if ((a == b) == (op == 6'h04)) begin
          nextPc = pcPlus4 + {immExt[29:0], 2'b00};
          if (op == 6'h04) begin
            reached["beq taken"] = 1'b1;
          end else begin
            reached["bne taken"] = 1'b1;
          end
        end else if (op == 6'h04) begin
          reached["beq not taken"] = 1'b1;
        end else begin
          reached["bne not taken"] = 1'b1;
        end
      end
      6'h02, 6'h03: begin
        testIdx = 4;
        nextPc  = {pcPlus4[31:28], instr[25:0], 2'b00};
        regWe   = (op == 6'h03);
        regAddr = linkReg;
        regData = pcPlus4;
        if (op == 6'h03) begin
          reached["jal"] = 1'b1;
        end else begin
          reached["j"] = 1'b1;
        end
      end
      default: begin
        $display("unknown opcode in %h at pc %h", instr, expPc);
        regWe = 1'b0;
        otherErrors++;
      end
    endcase
    checkValue(testIdx, "pc", expPc, trace.pc);
    checkValue(testIdx, "regWe", word_t'(regWe), word_t'(trace.regWe));
    if (regWe) begin
      checkValue(testIdx, "regAddr", word_t'(regAddr), word_t'(trace.regAddr));
      checkValue(testIdx, "regData", regData, trace.regData);
    end
    checkValue(testIdx, "memWe", word_t'(memWe), word_t'(trace.memWe));
    if (memWe) begin
      checkValue(testIdx, "memAddr", memAddr, trace.memAddr);
      checkValue(testIdx, "memData", b, trace.memData);
      shadowMem[memAddr] = b;
    end
    if (regWe && regAddr != '0) begin
      shadowRegs[regAddr] = regData;
    end
    // a jump to itself ends the program
    done  = (nextPc == expPc);
    expPc = nextPc;
  endtask

  initial begin : mainFlow
    int cycle;
    arstN = 1'b0;
    foreach (shadowRegs[i]) begin
      shadowRegs[i] = '0;
    end
    done        = 1'b0;
    otherErrors = 0;
    @(posedge clk);
    repeat (10) begin
      @(negedge clk);
      checkValue(0, "pc", resetPc, trace.pc);
      checkValue(0, "regWe", '0, word_t'(trace.regWe));
      checkValue(0, "memWe", '0, word_t'(trace.memWe));
      @(posedge clk);
    end
    arstN <= 1'b1;
    reportTest(0);
    expPc = resetPc;
    cycle = 0;
    while (!done && cycle < 200) begin
      @(negedge clk);
      retireOne();
      cycle++;
    end
    if (!done) begin
      $display("program did not reach its self-jump within 200 cycles");
      otherErrors++;
    end
    foreach (points[i]) begin
      checkCount[5]++;
      if (!reached.exists(points[i])) begin
        $display("coverage point %s was never reached", points[i]);
        failCount[5]++;
      end
    end
    totalChecks = 0;
    totalErrors = otherErrors + dut0.props0.violations;
    for (int t = 0; t < 6; t++) begin
      if (t > 0) begin
        reportTest(t);
      end
      totalChecks += checkCount[t];
      totalErrors += failCount[t];
    end
    $display("total: %0d checks, %0d errors", totalChecks, totalErrors);
    if (totalErrors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mipsSystem.f
mipsPkg.sv
mipsControl.sv
mipsAlu.sv
mipsRegFile.sv
mipsCpu.sv
mipsFetch.sv
mipsDataMem.sv
mipsSystem.sv
mipsSystem_properties.sv
tbMipsSystem.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tbMipsSystem
FILELIST = mipsSystem.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: program.hex
// one 32-bit instruction word per line, in hex, starting at byte address 0
// the text after each word gives its byte address and assembly
20010005 // 00: addi $1, $0, 5
2002FFFD // 04: addi $2, $0, -3
00221820 // 08: add  $3, $1, $2
00222022 // 0c: sub  $4, $1, $2
00222824 // 10: and  $5, $1, $2
00223025 // 14: or   $6, $1, $2
0041382A // 18: slt  $7, $2, $1
0022402A // 1c: slt  $8, $1, $2
00210020 // 20: add  $0, $1, $1
20090007 // 24: addi $9, $0, 7
AC230003 // 28: sw   $3, 3($1)
8C0A0008 // 2c: lw   $10, 8($0)
11430001 // 30: beq  $10, $3, 38
200B0063 // 34: addi $11, $0, 99
10220001 // 38: beq  $1, $2, 40
14220001 // 3c: bne  $1, $2, 44
200B0063 // 40: addi $11, $0, 99
14210001 // 44: bne  $1, $1, 4c
0C000016 // 48: jal  58
08000018 // 4c: j    60
200B0063 // 50: addi $11, $0, 99
200B0063 // 54: addi $11, $0, 99
200C0001 // 58: addi $12, $0, 1
03E00008 // 5c: jr   $31
08000018 // 60: j    60
